// ==== design/nnParams.svh ====
`ifndef NN_PARAMS_SVH
`define NN_PARAMS_SVH

// network shape.
`define NN_INPUTS 15
`define NN_HIDDEN 4
`define NN_CLASSES 3

// datapath widths.
`define NN_ACT_W 8
`define NN_ACC_W 16

// hidden result to 8-bit activation.
`define NN_REQUANT_SHIFT 5

// Weight tables are packed concatenations, so the leftmost entry lands in the
// highest index. Hidden rows run neuron 3 down to neuron 0, and inside each row
// the inputs run 14 down to 0.
`define NN_HIDDEN_WEIGHTS { \
	8'h0C, 8'hF4, 8'h1A, 8'h07, 8'h22, 8'hFB, 8'h10, 8'h09, \
	8'h15, 8'h03, 8'hEE, 8'h0B, 8'h19, 8'h06, 8'h11, \
	8'h05, 8'h13, 8'hF9, 8'h1E, 8'h08, 8'h0D, 8'hE9, 8'h17, \
	8'h0A, 8'h24, 8'h02, 8'hFA, 8'h12, 8'h0E, 8'h1B, \
	8'h21, 8'h04, 8'h0F, 8'hF2, 8'h16, 8'h09, 8'h1C, 8'h03, \
	8'hF7, 8'h14, 8'h0C, 8'h1D, 8'h06, 8'hEB, 8'h18, \
	8'h0A, 8'h1F, 8'h07, 8'h12, 8'hF3, 8'h25, 8'h0B, 8'h16, \
	8'h04, 8'hF8, 8'h1A, 8'h0D, 8'h13, 8'h02, 8'h0E \
}

// neuron 3 down to neuron 0.
`define NN_HIDDEN_BIAS { \
	8'hF6, 8'h08, 8'h0C, 8'hF2 \
}

// Output rows run class 2 down to class 0, each row hidden 3 down to 0.
`define NN_OUTPUT_WEIGHTS { \
	8'h21, 8'hF0, 8'h18, 8'h0D, \
	8'hE8, 8'h2A, 8'h0B, 8'h14, \
	8'h15, 8'h0C, 8'hEA, 8'h27 \
}

// class 2 down to class 0; class 1 has the largest bias.
`define NN_OUTPUT_BIAS { \
	8'h04, 8'h10, 8'h0A \
}

`endif

// ==== design/nnPkg.sv ====
`include "nnParams.svh"

package nnPkg;

	// one activation or weight.
	typedef logic signed [`NN_ACT_W-1:0] actT;

	// wrapping accumulator, also the class score.
	typedef logic signed [`NN_ACC_W-1:0] accT;

	typedef logic [$clog2(`NN_CLASSES)-1:0] classIdxT;

	// input sample, element 0 is the first activation.
	typedef actT [`NN_INPUTS-1:0] sampleT;

	// requantized hidden layer outputs.
	typedef actT [`NN_HIDDEN-1:0] hiddenVecT;

	// raw output layer scores.
	typedef accT [`NN_CLASSES-1:0] scoreVecT;

	// constant tables, indexed [neuron][input].
	typedef actT [`NN_HIDDEN-1:0][`NN_INPUTS-1:0] hiddenWeightT;
	typedef actT [`NN_HIDDEN-1:0] hiddenBiasT;
	typedef actT [`NN_CLASSES-1:0][`NN_HIDDEN-1:0] outputWeightT;
	typedef actT [`NN_CLASSES-1:0] outputBiasT;

	// what the classifier reports per sample.
	typedef struct packed
	{
		classIdxT classIdx;
		accT bestScore;
	} classResultT;

endpackage

// ==== design/macNeuron.sv ====
`include "nnParams.svh"

module macNeuron
#(
	parameter int nInputs = `NN_INPUTS,
	parameter nnPkg::actT [nInputs-1:0] weights = '0,
	parameter nnPkg::actT bias = '0
)
(
	input logic clk,
	input logic reset,
	input nnPkg::actT [nInputs-1:0] act,
	output nnPkg::accT relu
);

	import nnPkg::*;

	actT [nInputs-1:0] actReg; // stage 1.
	accT sum;
	accT sumReg; // stage 2.

	// stage 1, capture the activations.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
		end
		else
		begin
			actReg <= act;
		end
	end

	// Every term is evaluated at accumulator width, so the operands are sign
	// extended before the multiply and the total simply wraps at 16 bits.
	always_comb
	begin
		sum = bias; // sign extended.
		for (int i = 0; i < nInputs; i++)
		begin
			sum = sum + actReg[i] * weights[i];
		end
	end

	// stage 2, hold the weighted sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sum;
		end
	end

	// stage 3, relu on the true sign bit.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			relu <= '0;
		end
		else if (sumReg[`NN_ACC_W-1])
		begin
			relu <= '0; // negative sum.
		end
		else
		begin
			relu <= sumReg;
		end
	end

endmodule

// ==== design/neuronLayer.sv ====
`include "nnParams.svh"

module neuronLayer
#(
	parameter int nInputs = `NN_INPUTS,
	parameter int nNeurons = `NN_HIDDEN,
	parameter nnPkg::actT [nNeurons-1:0][nInputs-1:0] weights = '0,
	parameter nnPkg::actT [nNeurons-1:0] bias = '0,
	parameter bit requant = 1'b0,
	localparam int outW = requant ? `NN_ACT_W : `NN_ACC_W
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::actT [nInputs-1:0] act,
	output logic outValid,
	output logic [nNeurons-1:0][outW-1:0] outVec
);

	import nnPkg::*;

	// three neuron stages plus the output register.
	localparam int pipeDepth = 4;

	// largest positive activation.
	localparam int actMax = 2 ** (`NN_ACT_W - 1) - 1;

	logic [pipeDepth-1:0] validPipe;
	logic [nNeurons-1:0][outW-1:0] nextVec;

	// valid strobe follows the data through the neurons.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[pipeDepth-2:0], inValid};
		end
	end

	assign outValid = validPipe[pipeDepth-1];

	for (genvar n = 0; n < nNeurons; n++)
	begin : gNeuron
		accT relu;

		macNeuron
		#(
			.nInputs(nInputs),
			.weights(weights[n]),
			.bias(bias[n])
		)
		neuron
		(
			.clk(clk),
			.reset(reset),
			.act(act),
			.relu(relu)
		);

		if (requant)
		begin : gRequant
			accT shifted;

			// relu is never negative, so only the top needs a clamp.
			assign shifted = relu >>> `NN_REQUANT_SHIFT;
			assign nextVec[n] = (shifted > accT'(actMax)) ? outW'(actMax) : outW'(shifted);
		end
		else
		begin : gRaw
			assign nextVec[n] = relu; // score goes out at full width.
		end
	end

	// output register, the fourth stage.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outVec <= '0;
		end
		else
		begin
			outVec <= nextVec;
		end
	end

	validKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(outValid))
		else $error("outValid unknown after reset");

endmodule

// ==== design/classSelect.sv ====
`include "nnParams.svh"

module classSelect
(
	input logic clk,
	input logic reset,
	input logic scoreValid,
	input nnPkg::scoreVecT scores,
	output logic resultValid,
	output nnPkg::classResultT result
);

	import nnPkg::*;

	classIdxT bestIdx;
	accT bestScore;

	function automatic accT scoreAt(input scoreVecT s, input classIdxT idx);
		return s[idx];
	endfunction

	// Strict greater-than keeps the first maximum, so a tie goes to the
	// lowest class index.
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[0];
		for (int c = 1; c < `NN_CLASSES; c++)
		begin
			if (scores[c] > bestScore)
			begin
				bestIdx = classIdxT'(c);
				bestScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			result <= '0;
		end
		else
		begin
			resultValid <= scoreValid;
			result.classIdx <= bestIdx;
			result.bestScore <= bestScore;
		end
	end

	idxInRange: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> result.classIdx < `NN_CLASSES)
		else $error("class index out of range");

	// reported score is the one the index points at.
	scoreMatchesIdx: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> result.bestScore == scoreAt($past(scores), result.classIdx))
		else $error("best score does not match class index");

endmodule

// ==== design/nnClassifier.sv ====
`include "nnParams.svh"

module nnClassifier
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input nnPkg::sampleT sample,
	output logic resultValid,
	output nnPkg::classResultT result
);

	import nnPkg::*;

	localparam hiddenWeightT hiddenWeights = `NN_HIDDEN_WEIGHTS;
	localparam hiddenBiasT hiddenBias = `NN_HIDDEN_BIAS;
	localparam outputWeightT outputWeights = `NN_OUTPUT_WEIGHTS;
	localparam outputBiasT outputBias = `NN_OUTPUT_BIAS;

	logic hiddenValid;
	hiddenVecT hiddenVec;
	logic scoreValid;
	scoreVecT scores;

	// sample to 8-bit hidden activations, four cycles.
	neuronLayer
	#(
		.nInputs(`NN_INPUTS),
		.nNeurons(`NN_HIDDEN),
		.weights(hiddenWeights),
		.bias(hiddenBias),
		.requant(1'b1)
	)
	hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(sampleValid),
		.act(sample),
		.outValid(hiddenValid),
		.outVec(hiddenVec)
	);

	// hidden activations to raw class scores, four more.
	neuronLayer
	#(
		.nInputs(`NN_HIDDEN),
		.nNeurons(`NN_CLASSES),
		.weights(outputWeights),
		.bias(outputBias),
		.requant(1'b0)
	)
	outputLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.act(hiddenVec),
		.outValid(scoreValid),
		.outVec(scores)
	);

	// last cycle of the nine.
	classSelect classSelect
	(
		.clk(clk),
		.reset(reset),
		.scoreValid(scoreValid),
		.scores(scores),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

// ==== verif/nnScoreboard.sv ====
`include "nnParams.svh"

module nnScoreboard
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input nnPkg::classResultT expected,
	input logic resultValid,
	input nnPkg::classResultT result,
	output int mismatchCount,
	output int protocolCount,
	output int resultCount
);
	timeunit 1ns;
	timeprecision 100ps;

	import nnPkg::*;

	// sampleValid to resultValid, in cycles.
	localparam int unsigned latency = 9;

	typedef struct packed
	{
		classResultT expResult;
		int unsigned issueCycle;
	} pendingT;

	pendingT pending[$];
	pendingT head;
	pendingT entry;
	int unsigned cycle = 0;
	int mismatches = 0;
	int protocolErrors = 0;
	int checked = 0;

	assign mismatchCount = mismatches;
	assign protocolCount = protocolErrors;
	assign resultCount = checked;

	task automatic compareResult(input pendingT item);
		if (cycle - item.issueCycle != latency)
		begin
			$display("Error at %0t: result came %0d cycles after its sample instead of %0d",
				$time, cycle - item.issueCycle, latency);
			protocolErrors++;
		end
		if (result.classIdx !== item.expResult.classIdx)
		begin
			$display("Mismatch at %0t: class %0d, expected %0d",
				$time, result.classIdx, item.expResult.classIdx);
			mismatches++;
		end
		if (result.bestScore !== item.expResult.bestScore)
		begin
			$display("Mismatch at %0t: best score %0d, expected %0d",
				$time, result.bestScore, item.expResult.bestScore);
			mismatches++;
		end
		checked++;
	endtask

	// inputs and registered outputs are all settled at the falling edge.
	always @(negedge clk)
	begin
		cycle = cycle + 1;
		if (reset)
		begin
			if (resultValid !== 1'b0)
			begin
				$display("Error at %0t: resultValid is not low during reset", $time);
				protocolErrors++;
			end
			pending.delete();
		end
		else
		begin
			if (resultValid === 1'b1)
			begin
				if (pending.size() == 0)
				begin
					$display("Error at %0t: a result arrived with no sample in flight", $time);
					protocolErrors++;
				end
				else
				begin
					head = pending.pop_front();
					compareResult(head);
				end
			end
			else if (resultValid !== 1'b0)
			begin
				$display("Error at %0t: resultValid is unknown", $time);
				protocolErrors++;
			end
			if (pending.size() > 0 && cycle - pending[0].issueCycle > latency)
			begin
				$display("Error at %0t: no result %0d cycles after its sample", $time, latency);
				protocolErrors++;
				head = pending.pop_front(); // dropped.
			end
			if (sampleValid === 1'b1)
			begin
				entry.expResult = expected;
				entry.issueCycle = cycle;
				pending.push_back(entry);
			end
		end
	end

endmodule

// ==== verif/nnClassifierTb.sv ====
`include "nnParams.svh"

module nnClassifierTb;
	timeunit 1ns;
	timeprecision 100ps;

	import nnPkg::*;

	localparam int numVectors = 16;
	localparam int wordsPerVector = `NN_INPUTS + 2; // activations, class, score.
	localparam int numPasses = 2;
	localparam int resetCycles = 10;
	localparam int quietCycles = 12; // longer than the pipeline.
	localparam int drainTimeout = 200;

	logic clk = 1'b0;
	logic reset;
	logic sampleValid;
	sampleT sample;
	logic resultValid;
	classResultT result;
	classResultT expected;

	int mismatchCount;
	int protocolCount;
	int resultCount;

	logic [15:0] vectors [0:numVectors*wordsPerVector-1];

	nnClassifier i_dut
	(
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sample(sample),
		.resultValid(resultValid),
		.result(result)
	);

	nnScoreboard scoreboard
	(
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.expected(expected),
		.resultValid(resultValid),
		.result(result),
		.mismatchCount(mismatchCount),
		.protocolCount(protocolCount),
		.resultCount(resultCount)
	);

	always #4 clk = ~clk;

	task automatic sendSample(input int index);
		int base;
		base = index * wordsPerVector;
		@(posedge clk);
		#1;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			sample[i] = actT'(vectors[base + i]);
		end
		expected.classIdx = classIdxT'(vectors[base + `NN_INPUTS]);
		expected.bestScore = accT'(vectors[base + `NN_INPUTS + 1]);
		sampleValid = 1'b1;
	endtask

	task automatic idleCycles(input int count);
		for (int n = 0; n < count; n++)
		begin
			@(posedge clk);
			#1;
			sampleValid = 1'b0;
		end
	endtask

	initial
	begin
		int sent;
		int waited;
		int timeouts;
		int errors;
		reset = 1'b1;
		sampleValid = 1'b0;
		sample = '0;
		expected = '0;
		sent = 0;
		timeouts = 0;
		void'($urandom(32'hbc67));
		$readmemh("verif/nnVectors.txt", vectors);
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		idleCycles(quietCycles); // output must stay quiet here.
		for (int pass = 0; pass < numPasses; pass++)
		begin
			for (int v = 0; v < numVectors; v++)
			begin
				sendSample(v);
				sent++;
				if (pass > 0)
				begin
					idleCycles($urandom_range(2)); // first pass is back-to-back.
				end
			end
		end
		idleCycles(1);
		waited = 0;
		while (resultCount < sent && waited < drainTimeout)
		begin
			@(posedge clk);
			waited++;
		end
		if (resultCount < sent)
		begin
			$display("Error: %0d of %0d results still missing after %0d cycles",
				sent - resultCount, sent, drainTimeout);
			timeouts = 1;
		end
		errors = mismatchCount + protocolCount + timeouts;
		$display("Errors: %0d mismatch, %0d protocol, %0d timeout, %0d of %0d results checked",
			mismatchCount, protocolCount, timeouts, resultCount, sent);
		if (errors == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== verif/nnVectors.txt ====
// columns: 15 activations (element 0 first), expected class, expected best score.
// all values hex, activations and score are two's complement.
// all-zero input, hidden sums stay below one requant step, scores are the biases.
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0010
// negative hidden sums, relu zeroes all four.
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF 1 0010
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 1 0010
// full scale positive, every hidden activation clamps at 127.
7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 2 1ACE
// largest reachable hidden sum, 31679 on neuron 1.
7F 80 7F 7F 7F 7F 80 7F 7F 7F 7F 80 7F 7F 7F 2 1ACE
// mixed-sign classification.
28 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0662
00 00 00 00 14 00 00 00 00 32 E2 00 00 00 00 0 0D8F
00 F6 00 00 00 00 00 00 00 00 3C 00 00 00 EC 2 0912
00 00 00 00 00 19 00 00 F1 00 00 0A 00 FB 00 1 0772
00 00 1E 0C 00 00 D8 00 00 00 00 00 00 00 00 2 0382
00 00 00 00 00 00 00 64 00 00 00 00 00 9C 00 2 07A5
CE 00 00 00 00 3C 00 00 00 00 00 00 00 00 0F 1 0523
00 00 00 EC 00 00 00 00 00 00 00 BA 5A 00 00 2 0B9E
// two hidden activations clamp, two do not.
00 00 00 00 00 00 00 00 00 7F 7F 00 00 00 40 2 1C45
// ties, class 0 and 1 at 251, then class 1 and 2 at 78.
00 00 00 00 00 00 00 00 04 08 00 00 FF 00 00 0 00FB
00 00 00 00 00 00 00 00 02 02 00 00 00 00 00 1 004E

// ==== filelist.f ====
+incdir+design
design/nnPkg.sv
design/macNeuron.sv
design/neuronLayer.sv
design/classSelect.sv
design/nnClassifier.sv
verif/nnScoreboard.sv
verif/nnClassifierTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= nnClassifierTb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale $(TIMESCALE)

SOURCES := $(wildcard design/*.sv design/*.svh verif/*.sv)
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
